// ==== verilog/scene_pkg.sv ====
package scene_pkg;

    typedef logic [9:0]  coord_t;     // scan or position coordinate
    typedef logic [4:0]  grid_x_t;    // tile column
    typedef logic [3:0]  grid_y_t;    // tile row
    typedef logic [3:0]  tile_t;
    typedef logic [16:0] rom_addr_t;
    typedef logic [7:0]  img_w_t;
    typedef logic [2:0]  frame_t;

    typedef enum logic [3:0] {
        SCENE_START = 4'd0,
        SCENE_PLAY  = 4'd1,
        SCENE_LOSE  = 4'd2,
        SCENE_WIN   = 4'd3
    } scene_t;

    localparam int TILE_PX  = 32;
    localparam int MAP_COLS = 20;
    localparam int MAP_ROWS = 15;
    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // character hit box is trimmed inside the 32x32 cell
    localparam int WIN_LEFT  = 3;
    localparam int WIN_RIGHT = 3;
    localparam int WIN_TOP   = 5;

    localparam coord_t P0_X = 10'd32;
    localparam coord_t P0_Y = 10'd320;
    localparam coord_t P1_X = 10'd32;
    localparam coord_t P1_Y = 10'd416;

    localparam tile_t T_EMPTY   = 4'd0;
    localparam tile_t T_SPIKE   = 4'd1;
    localparam tile_t T_SPIKE_L = 4'd2;
    localparam tile_t T_GATE_1  = 4'd3;
    localparam tile_t T_GATE_2  = 4'd4;
    localparam tile_t T_GATE_3  = 4'd5;
    localparam tile_t T_PLATE_1 = 4'd6;
    localparam tile_t T_PLATE_2 = 4'd7;
    localparam tile_t T_PLATE_3 = 4'd8;
    localparam tile_t T_EXIT    = 4'd9;
    localparam tile_t T_WALL    = 4'd10;
    localparam tile_t T_GOLD    = 4'd11;

    // full-screen pictures, stored downscaled
    localparam rom_addr_t START_BASE  = 17'd24576;
    localparam img_w_t    START_W     = 8'd160;
    localparam int        START_SHIFT = 2;
    localparam rom_addr_t LOSE_BASE   = 17'd43776;
    localparam img_w_t    LOSE_W      = 8'd80;
    localparam int        LOSE_SHIFT  = 3;
    localparam rom_addr_t WIN_BASE    = 17'd48576;
    localparam img_w_t    WIN_W       = 8'd80;
    localparam int        WIN_SHIFT   = 3;

    // character strips, one 32 px frame after the other
    localparam rom_addr_t P0_IDLE_BASE = 17'd1024;
    localparam img_w_t    P0_IDLE_W    = 8'd128;
    localparam rom_addr_t P0_WALK_BASE = 17'd5120;
    localparam img_w_t    P0_WALK_W    = 8'd192;
    localparam rom_addr_t P1_IDLE_BASE = 17'd13312;
    localparam img_w_t    P1_IDLE_W    = 8'd128;
    localparam rom_addr_t P1_WALK_BASE = 17'd17408;
    localparam img_w_t    P1_WALK_W    = 8'd192;

    localparam img_w_t    TILE_W       = 8'd32;
    localparam rom_addr_t WALL_BASE    = 17'd0;     // plates share the wall image
    localparam rom_addr_t EXIT_BASE    = 17'd11264;
    localparam rom_addr_t GATE_BASE    = 17'd12288;
    localparam rom_addr_t SPIKE_BASE   = 17'd23552;
    localparam rom_addr_t SPIKE_L_BASE = 17'd63616;
    localparam rom_addr_t GOLD_BASE    = 17'd64640;

    // index 0 is row 0 / column 0, so a row concatenation reads left to right
    typedef logic [0:MAP_COLS-1][3:0] map_row_t;
    typedef logic [0:MAP_ROWS-1][0:MAP_COLS-1][3:0] map_t;

    localparam map_t MAP_INIT = {
        map_row_t'({20{T_EMPTY}}),
        map_row_t'({{10{T_EMPTY}}, {10{T_WALL}}}),
        map_row_t'({20{T_EMPTY}}),
        map_row_t'({{10{T_WALL}}, {10{T_EMPTY}}}),
        map_row_t'({20{T_EMPTY}}),
        map_row_t'({{10{T_WALL}}, {10{T_EMPTY}}}),
        map_row_t'({20{T_EMPTY}}),
        map_row_t'({{2{T_GOLD}}, {8{T_WALL}}, {10{T_EMPTY}}}),
        map_row_t'({20{T_EMPTY}}),
        map_row_t'({{7{T_EMPTY}}, T_GATE_1, {4{T_EMPTY}}, T_GATE_2, {4{T_EMPTY}},
                    T_GATE_3, T_EMPTY, T_EXIT}),
        map_row_t'({{4{T_EMPTY}}, T_EXIT, T_SPIKE, T_EMPTY, T_GATE_1, {4{T_EMPTY}},
                    T_GATE_2, {4{T_EMPTY}}, T_GATE_3, T_EMPTY, T_EXIT}),
        map_row_t'({T_WALL, T_GOLD, {3{T_PLATE_1}}, {15{T_WALL}}}),
        map_row_t'({{19{T_EMPTY}}, T_EXIT}),
        map_row_t'({{2{T_EMPTY}}, T_EXIT, T_SPIKE, T_EMPTY, T_GATE_1, {9{T_EMPTY}},
                    {5{T_PLATE_3}}}),
        map_row_t'({{5{T_WALL}}, {5{T_PLATE_1}}, {5{T_PLATE_2}}, {5{T_WALL}}})
    };

endpackage

// ==== verilog/tile_map_store.sv ====
module tile_map_store (
    input  logic              clk,
    input  logic              rst,
    input  scene_pkg::scene_t scene,
    input  scene_pkg::coord_t h_cnt,
    input  scene_pkg::coord_t v_cnt,
    input  scene_pkg::coord_t p0_x,
    input  scene_pkg::coord_t p0_y,
    input  scene_pkg::coord_t p1_x,
    input  scene_pkg::coord_t p1_y,
    output scene_pkg::tile_t  cur_tile
);
    import scene_pkg::*;

    map_t map_q;

    // pickup cell per player, column taken at the sprite's horizontal centre
    logic [10:0] p0_cx;
    logic [10:0] p1_cx;
    grid_x_t     p0_col;
    grid_x_t     p1_col;
    grid_y_t     p0_row;
    grid_y_t     p1_row;
    logic        p0_ok;
    logic        p1_ok;
    logic        p0_gold;
    logic        p1_gold;

    // scan side
    grid_x_t     scan_col;
    grid_y_t     scan_row;
    logic        scan_on;

    assign p0_cx  = {1'b0, p0_x} + 11'(TILE_PX / 2);
    assign p1_cx  = {1'b0, p1_x} + 11'(TILE_PX / 2);
    assign p0_col = grid_x_t'(p0_cx / TILE_PX);
    assign p1_col = grid_x_t'(p1_cx / TILE_PX);
    assign p0_row = grid_y_t'(p0_y / TILE_PX);
    assign p1_row = grid_y_t'(p1_y / TILE_PX);

    // a player past the screen edge has no cell to pick from
    assign p0_ok = (p0_cx < 11'(SCREEN_W)) && (p0_y < coord_t'(SCREEN_H));
    assign p1_ok = (p1_cx < 11'(SCREEN_W)) && (p1_y < coord_t'(SCREEN_H));

    assign p0_gold = p0_ok && (map_q[p0_row][p0_col] == T_GOLD);
    assign p1_gold = p1_ok && (map_q[p1_row][p1_col] == T_GOLD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map_q <= MAP_INIT;
        end else begin
            case (scene)
                SCENE_START: begin
                    map_q <= MAP_INIT;  // fresh level every time the game restarts
                end
                SCENE_PLAY: begin
                    if (p0_gold) begin
                        map_q[p0_row][p0_col] <= T_WALL;
                    end
                    if (p1_gold) begin
                        map_q[p1_row][p1_col] <= T_WALL;
                    end
                end
                default: begin
                    map_q <= map_q;     // lose/win keep the last layout
                end
            endcase
        end
    end

    assign scan_col = grid_x_t'(h_cnt / TILE_PX);
    assign scan_row = grid_y_t'(v_cnt / TILE_PX);
    assign scan_on  = (h_cnt < coord_t'(SCREEN_W)) && (v_cnt < coord_t'(SCREEN_H));

    // blanking area reads as empty
    assign cur_tile = scan_on ? tile_t'(map_q[scan_row][scan_col]) : T_EMPTY;

endmodule

// ==== verilog/player_window.sv ====
module player_window #(
    parameter scene_pkg::coord_t RST_POS [2] = '{scene_pkg::P0_X, scene_pkg::P0_Y}
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_start,
    input  scene_pkg::coord_t h_cnt,
    input  scene_pkg::coord_t v_cnt,
    input  scene_pkg::coord_t pos_x,
    input  scene_pkg::coord_t pos_y,
    input  scene_pkg::frame_t frame,
    input  logic              face_left,
    output logic              hit,
    output scene_pkg::coord_t loc_x,
    output scene_pkg::coord_t loc_y
);
    import scene_pkg::*;

    coord_t      pos_x_q;   // shadow position, one per frame
    coord_t      pos_y_q;
    logic [10:0] x_lo;
    logic [10:0] x_hi;
    logic [10:0] y_lo;
    logic [10:0] y_hi;
    logic [4:0]  rel_x;
    logic [4:0]  col;

    // latch once per frame so the sprite never tears mid-screen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_x_q <= RST_POS[0];
            pos_y_q <= RST_POS[1];
        end else if (frame_start) begin
            pos_x_q <= pos_x;
            pos_y_q <= pos_y;
        end
    end

    // window bounds kept 11 bits wide, no wrap near the right edge
    assign x_lo = {1'b0, pos_x_q} + 11'(WIN_LEFT);
    assign x_hi = {1'b0, pos_x_q} + 11'(TILE_PX - WIN_RIGHT);
    assign y_lo = {1'b0, pos_y_q} + 11'(WIN_TOP);
    assign y_hi = {1'b0, pos_y_q} + 11'(TILE_PX);

    assign hit = ({1'b0, h_cnt} >= x_lo) && ({1'b0, h_cnt} < x_hi) &&
                 ({1'b0, v_cnt} >= y_lo) && ({1'b0, v_cnt} < y_hi);

    assign rel_x = h_cnt[4:0] - pos_x_q[4:0];       // column inside the cell, mod 32
    assign col   = face_left ? (5'd31 - rel_x) : rel_x;

    // frame picks the 32 px slot in the strip
    assign loc_x = {2'b00, frame, col};
    assign loc_y = v_cnt - pos_y_q;

endmodule

// ==== verilog/tile_decode.sv ====
module tile_decode (
    input  scene_pkg::tile_t     cur_tile,
    input  logic [2:0]           gate_open,
    input  logic                 spike_on,
    output logic                 tile_vis,
    output scene_pkg::rom_addr_t tile_base
);
    import scene_pkg::*;

    always_comb begin
        tile_vis  = (cur_tile != T_EMPTY);
        tile_base = WALL_BASE;
        case (cur_tile)
            T_EMPTY: begin
                tile_base = '0;
            end
            T_SPIKE: begin
                tile_vis  = spike_on;           // spikes retract when off
                tile_base = SPIKE_BASE;
            end
            T_SPIKE_L: begin
                tile_base = SPIKE_L_BASE;
            end
            T_GATE_1: begin
                tile_vis  = !gate_open[0];
                tile_base = GATE_BASE;
            end
            T_GATE_2: begin
                tile_vis  = !gate_open[1];
                tile_base = GATE_BASE;
            end
            T_GATE_3: begin
                tile_vis  = !gate_open[2];
                tile_base = GATE_BASE;
            end
            T_PLATE_1, T_PLATE_2, T_PLATE_3, T_WALL: begin
                tile_base = WALL_BASE;
            end
            T_EXIT: begin
                tile_base = EXIT_BASE;
            end
            T_GOLD: begin
                tile_base = GOLD_BASE;
            end
            default: begin
                tile_base = WALL_BASE;          // unused codes fall back to wall art
            end
        endcase
    end

endmodule

// ==== verilog/pixel_addr_unit.sv ====
module pixel_addr_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  scene_pkg::scene_t    scene,
    input  scene_pkg::coord_t    h_cnt,
    input  scene_pkg::coord_t    v_cnt,
    input  scene_pkg::tile_t     cur_tile,
    input  logic                 tile_vis,
    input  scene_pkg::rom_addr_t tile_base,
    input  logic                 c0_hit,
    input  logic                 c1_hit,
    input  scene_pkg::coord_t    c0_loc_x,
    input  scene_pkg::coord_t    c0_loc_y,
    input  scene_pkg::coord_t    c1_loc_x,
    input  scene_pkg::coord_t    c1_loc_y,
    input  logic                 c0_moving,
    input  logic                 c1_moving,
    output scene_pkg::rom_addr_t pixel_addr,
    output logic                 show_pixel,
    output logic                 char0_on,
    output logic                 char1_on,
    output scene_pkg::tile_t     tile_id
);
    import scene_pkg::*;

    localparam int FLAG_W = 7;  // show, tile code, char0, char1

    rom_addr_t        sel_base;
    img_w_t           sel_w;
    coord_t           sel_x;
    coord_t           sel_y;
    logic [FLAG_W-1:0] flag_in;
    logic [FLAG_W-1:0] flag_q [3];

    always_comb begin
        sel_base = '0;
        sel_w    = '0;
        sel_x    = '0;
        sel_y    = '0;
        case (scene)
            SCENE_START: begin
                sel_base = START_BASE;
                sel_w    = START_W;
                sel_x    = h_cnt >> START_SHIFT;
                sel_y    = v_cnt >> START_SHIFT;
            end
            SCENE_LOSE: begin
                sel_base = LOSE_BASE;
                sel_w    = LOSE_W;
                sel_x    = h_cnt >> LOSE_SHIFT;
                sel_y    = v_cnt >> LOSE_SHIFT;
            end
            SCENE_WIN: begin
                sel_base = WIN_BASE;
                sel_w    = WIN_W;
                sel_x    = h_cnt >> WIN_SHIFT;
                sel_y    = v_cnt >> WIN_SHIFT;
            end
            SCENE_PLAY: begin
                // map tiles are drawn over the characters
                if (tile_vis) begin
                    sel_base = tile_base;
                    sel_w    = TILE_W;
                    sel_x    = {5'b0, h_cnt[4:0]};
                    sel_y    = {5'b0, v_cnt[4:0]};
                end else if (c0_hit) begin
                    sel_base = c0_moving ? P0_WALK_BASE : P0_IDLE_BASE;
                    sel_w    = c0_moving ? P0_WALK_W : P0_IDLE_W;
                    sel_x    = c0_loc_x;
                    sel_y    = c0_loc_y;
                end else if (c1_hit) begin
                    sel_base = c1_moving ? P1_WALK_BASE : P1_IDLE_BASE;
                    sel_w    = c1_moving ? P1_WALK_W : P1_IDLE_W;
                    sel_x    = c1_loc_x;
                    sel_y    = c1_loc_y;
                end
            end
            default: ;  // unknown scene reads address 0
        endcase
    end

    // show uses the raw tile code, so a hidden gate or spike still flags the pixel
    assign flag_in = {(c0_hit || c1_hit || (cur_tile != T_EMPTY)), cur_tile, c0_hit, c1_hit};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_addr <= '0;
            flag_q[0]  <= '0;
            flag_q[1]  <= '0;
            flag_q[2]  <= '0;
        end else begin
            pixel_addr <= sel_base + rom_addr_t'(sel_y) * rom_addr_t'(sel_w)
                          + rom_addr_t'(sel_x);
            // three stages: address reg plus two ROM read cycles
            flag_q[0]  <= flag_in;
            flag_q[1]  <= flag_q[0];
            flag_q[2]  <= flag_q[1];
        end
    end

    assign {show_pixel, tile_id, char0_on, char1_on} = flag_q[2];

endmodule

// ==== verilog/scene_addr_gen.sv ====
module scene_addr_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  scene_pkg::coord_t    h_cnt,
    input  scene_pkg::coord_t    v_cnt,
    input  logic                 frame_start,
    input  logic                 spike_on,
    input  scene_pkg::scene_t    scene,
    input  logic [2:0]           gate_open,
    input  scene_pkg::coord_t    p0_x,
    input  scene_pkg::coord_t    p0_y,
    input  scene_pkg::coord_t    p1_x,
    input  scene_pkg::coord_t    p1_y,
    input  scene_pkg::frame_t    p0_frame,
    input  scene_pkg::frame_t    p1_frame,
    input  logic                 p0_moving,
    input  logic                 p1_moving,
    input  logic                 p0_face_left,
    input  logic                 p1_face_left,
    output scene_pkg::rom_addr_t pixel_addr,
    output logic                 show_pixel,
    output scene_pkg::tile_t     tile_id,
    output logic                 char0_on,
    output logic                 char1_on
);
    import scene_pkg::*;

    tile_t     cur_tile;
    logic      tile_vis;
    rom_addr_t tile_base;
    logic      c0_hit;
    logic      c1_hit;
    coord_t    c0_loc_x;
    coord_t    c0_loc_y;
    coord_t    c1_loc_x;
    coord_t    c1_loc_y;

    // pickup uses the live positions, drawing uses the frame-latched ones
    tile_map_store map0 (
        .clk      (clk),
        .rst      (rst),
        .scene    (scene),
        .h_cnt    (h_cnt),
        .v_cnt    (v_cnt),
        .p0_x     (p0_x),
        .p0_y     (p0_y),
        .p1_x     (p1_x),
        .p1_y     (p1_y),
        .cur_tile (cur_tile)
    );

    player_window #(.RST_POS('{P0_X, P0_Y})) pw0 (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .h_cnt       (h_cnt),
        .v_cnt       (v_cnt),
        .pos_x       (p0_x),
        .pos_y       (p0_y),
        .frame       (p0_frame),
        .face_left   (p0_face_left),
        .hit         (c0_hit),
        .loc_x       (c0_loc_x),
        .loc_y       (c0_loc_y)
    );

    player_window #(.RST_POS('{P1_X, P1_Y})) pw1 (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .h_cnt       (h_cnt),
        .v_cnt       (v_cnt),
        .pos_x       (p1_x),
        .pos_y       (p1_y),
        .frame       (p1_frame),
        .face_left   (p1_face_left),
        .hit         (c1_hit),
        .loc_x       (c1_loc_x),
        .loc_y       (c1_loc_y)
    );

    tile_decode dec0 (
        .cur_tile  (cur_tile),
        .gate_open (gate_open),
        .spike_on  (spike_on),
        .tile_vis  (tile_vis),
        .tile_base (tile_base)
    );

    pixel_addr_unit pau0 (
        .clk        (clk),
        .rst        (rst),
        .scene      (scene),
        .h_cnt      (h_cnt),
        .v_cnt      (v_cnt),
        .cur_tile   (cur_tile),
        .tile_vis   (tile_vis),
        .tile_base  (tile_base),
        .c0_hit     (c0_hit),
        .c1_hit     (c1_hit),
        .c0_loc_x   (c0_loc_x),
        .c0_loc_y   (c0_loc_y),
        .c1_loc_x   (c1_loc_x),
        .c1_loc_y   (c1_loc_y),
        .c0_moving  (p0_moving),
        .c1_moving  (p1_moving),
        .pixel_addr (pixel_addr),
        .show_pixel (show_pixel),
        .char0_on   (char0_on),
        .char1_on   (char1_on),
        .tile_id    (tile_id)
    );

endmodule

// ==== test/tb_scene_addr_gen.sv ====
module tb_scene_addr_gen;
    import scene_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int STREAM_N   = 64;

    typedef struct {
        scene_t     scene;
        int         h;
        int         v;
        int         p0x;
        int         p0y;
        int         p1x;
        int         p1y;
        int         f0;
        int         f1;
        bit         mv0;
        bit         mv1;
        bit         fl0;
        bit         fl1;
        logic [2:0] gate;
        bit         spike;
        bit         fs;         // pulse frame_start with this row
        bit         fixed;      // expected values given in the table
        int         exp_addr;
        bit         exp_show;
        int         exp_tile;
        bit         exp_c0;
        bit         exp_c1;
    } row_t;

    logic       clk;
    logic       rst;
    coord_t     h_cnt;
    coord_t     v_cnt;
    logic       frame_start;
    logic       spike_on;
    scene_t     scene;
    logic [2:0] gate_open;
    coord_t     p0_x;
    coord_t     p0_y;
    coord_t     p1_x;
    coord_t     p1_y;
    frame_t     p0_frame;
    frame_t     p1_frame;
    logic       p0_moving;
    logic       p1_moving;
    logic       p0_face_left;
    logic       p1_face_left;
    rom_addr_t  pixel_addr;
    logic       show_pixel;
    tile_t      tile_id;
    logic       char0_on;
    logic       char1_on;

    row_t        tbl[$];
    row_t        cur;           // template for the next table row
    bit          tbl_ready;
    logic [31:0] rng;
    map_t        ref_map;       // layout with pickups applied
    int          lat_x[2];
    int          lat_y[2];

    scene_addr_gen dut0 (
        .clk          (clk),
        .rst          (rst),
        .h_cnt        (h_cnt),
        .v_cnt        (v_cnt),
        .frame_start  (frame_start),
        .spike_on     (spike_on),
        .scene        (scene),
        .gate_open    (gate_open),
        .p0_x         (p0_x),
        .p0_y         (p0_y),
        .p1_x         (p1_x),
        .p1_y         (p1_y),
        .p0_frame     (p0_frame),
        .p1_frame     (p1_frame),
        .p0_moving    (p0_moving),
        .p1_moving    (p1_moving),
        .p0_face_left (p0_face_left),
        .p1_face_left (p1_face_left),
        .pixel_addr   (pixel_addr),
        .show_pixel   (show_pixel),
        .tile_id      (tile_id),
        .char0_on     (char0_on),
        .char1_on     (char1_on)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic set_players(input int x0, input int y0, input int x1, input int y1,
                               input bit fs);
        cur.p0x = x0;
        cur.p0y = y0;
        cur.p1x = x1;
        cur.p1y = y1;
        cur.fs  = fs;
    endtask

    task automatic set_look(input int f0, input bit mv0, input bit fl0,
                            input int f1, input bit mv1, input bit fl1);
        cur.f0  = f0;
        cur.mv0 = mv0;
        cur.fl0 = fl0;
        cur.f1  = f1;
        cur.mv1 = mv1;
        cur.fl1 = fl1;
    endtask

    task automatic set_env(input logic [2:0] gate, input bit spike);
        cur.gate  = gate;
        cur.spike = spike;
    endtask

    task automatic add_pix(input scene_t s, input int h, input int v);
        row_t r;
        r       = cur;
        r.scene = s;
        r.h     = h;
        r.v     = v;
        r.fixed = 1'b0;
        tbl.push_back(r);
        cur.fs = 1'b0;          // strobe only on the first row after a move
    endtask

    task automatic add_fixed(input scene_t s, input int h, input int v, input int addr,
                             input bit show, input int tile, input bit c0, input bit c1);
        row_t r;
        r          = cur;
        r.scene    = s;
        r.h        = h;
        r.v        = v;
        r.fixed    = 1'b1;
        r.exp_addr = addr;
        r.exp_show = show;
        r.exp_tile = tile;
        r.exp_c0   = c0;
        r.exp_c1   = c1;
        tbl.push_back(r);
        cur.fs = 1'b0;
    endtask

    task automatic build_table();
        set_players(32, 320, 32, 416, 1'b0);
        set_look(0, 1'b0, 1'b0, 0, 1'b0, 1'b0);
        set_env(3'b000, 1'b1);
        // reset windows
        add_pix(SCENE_PLAY, 40, 330);
        add_pix(SCENE_PLAY, 40, 430);
        add_pix(SCENE_PLAY, 34, 330);
        add_pix(SCENE_PLAY, 40, 324);
        // full-screen pictures
        add_fixed(SCENE_START, 100, 40, 26201, 1'b0, 0, 1'b0, 1'b0);
        add_pix(SCENE_START, 0, 0);
        add_pix(SCENE_LOSE, 100, 40);
        add_pix(SCENE_WIN, 639, 479);
        // tiles, spikes and gates
        add_fixed(SCENE_PLAY, 5, 455, 229, 1'b1, 10, 1'b0, 1'b0);
        set_env(3'b000, 1'b0);
        add_fixed(SCENE_PLAY, 170, 330, 0, 1'b1, 1, 1'b0, 1'b0);
        set_env(3'b000, 1'b1);
        add_pix(SCENE_PLAY, 170, 330);
        set_env(3'b010, 1'b1);
        add_pix(SCENE_PLAY, 391, 297);
        set_env(3'b101, 1'b1);
        add_pix(SCENE_PLAY, 391, 297);
        add_pix(SCENE_PLAY, 227, 323);      // gate 1 held open
        set_env(3'b000, 1'b1);
        add_pix(SCENE_PLAY, 700, 100);
        add_pix(SCENE_PLAY, 100, 500);
        // live move without strobe and then with it
        set_players(200, 64, 400, 128, 1'b0);
        add_pix(SCENE_PLAY, 40, 330);
        add_pix(SCENE_PLAY, 210, 80);
        set_players(200, 64, 400, 128, 1'b1);
        add_pix(SCENE_PLAY, 210, 80);
        for (int mv = 0; mv < 2; mv++) begin
            for (int fl = 0; fl < 2; fl++) begin
                set_look(3, mv[0], fl[0], 2, mv[0], fl[0]);
                add_pix(SCENE_PLAY, 203, 69);   // window corners
                add_pix(SCENE_PLAY, 228, 95);
                add_pix(SCENE_PLAY, 210, 80);
                add_pix(SCENE_PLAY, 202, 80);   // just outside
                add_pix(SCENE_PLAY, 229, 80);
                add_pix(SCENE_PLAY, 210, 68);
                add_pix(SCENE_PLAY, 403, 133);
                add_pix(SCENE_PLAY, 428, 159);
                add_pix(SCENE_PLAY, 415, 140);
                add_pix(SCENE_PLAY, 402, 140);
                add_pix(SCENE_PLAY, 415, 160);
            end
        end
        // player 1 steps onto gold at row 11 column 1
        set_players(200, 64, 32, 360, 1'b1);
        add_fixed(SCENE_PLAY, 36, 358, 196, 1'b1, 10, 1'b0, 1'b0);
        add_fixed(SCENE_PLAY, 10, 227, 64746, 1'b1, 11, 1'b0, 1'b0);
        add_pix(SCENE_PLAY, 40, 370);
        add_pix(scene_t'(4'd6), 36, 358);   // unused scene code keeps the map and reads 0
        set_players(200, 64, 400, 128, 1'b1);
        add_pix(SCENE_START, 36, 358);
        add_fixed(SCENE_PLAY, 36, 358, 64836, 1'b1, 11, 1'b0, 1'b0);
        for (int k = 0; k < 12; k++) begin
            rng = lcg_next(rng);
            add_pix(SCENE_PLAY, int'(rng[25:16]) % 800, int'(rng[9:0]) % 525);
        end
    endtask

    function automatic int model_tile(input int h, input int v);
        if (h >= 640 || v >= 480) begin
            return 0;
        end
        return int'(ref_map[v / 32][h / 32]);
    endfunction

    function automatic int tile_rom_base(input int t);
        case (t)
            1:       return 23552;
            2:       return 63616;
            3, 4, 5: return 12288;
            9:       return 11264;
            11:      return 64640;
            default: return 0;      // wall and the plates
        endcase
    endfunction

    function automatic bit tile_shown(input int t, input logic [2:0] gate, input bit spike);
        if (t == 0) begin
            return 1'b0;
        end
        if (t == 1) begin
            return spike;
        end
        if (t >= 3 && t <= 5) begin
            return !gate[t - 3];
        end
        return 1'b1;
    endfunction

    function automatic bit in_window(input int k, input int h, input int v);
        return h >= lat_x[k] + 3 && h < lat_x[k] + 29 && v >= lat_y[k] + 5 && v < lat_y[k] + 32;
    endfunction

    function automatic int sprite_addr(input int k, input row_t r);
        int rel;
        int col;
        int fr;
        bit mv;
        bit fl;
        fr  = (k == 0) ? r.f0 : r.f1;
        mv  = (k == 0) ? r.mv0 : r.mv1;
        fl  = (k == 0) ? r.fl0 : r.fl1;
        rel = ((r.h - lat_x[k]) % 32 + 32) % 32;
        col = fl ? 31 - rel : rel;  // mirrored when facing left
        if (k == 0) begin
            return (mv ? 5120 : 1024) + (r.v - lat_y[k]) * (mv ? 192 : 128) + fr * 32 + col;
        end
        return (mv ? 17408 : 13312) + (r.v - lat_y[k]) * (mv ? 192 : 128) + fr * 32 + col;
    endfunction

    function automatic row_t model_expect(input row_t r);
        row_t e;
        int   t;
        bit   h0;
        bit   h1;
        e          = r;
        t          = model_tile(r.h, r.v);
        h0         = in_window(0, r.h, r.v);
        h1         = in_window(1, r.h, r.v);
        e.exp_tile = t;
        e.exp_show = h0 || h1 || (t != 0);
        e.exp_c0   = h0;
        e.exp_c1   = h1;
        case (r.scene)
            SCENE_START: e.exp_addr = 24576 + (r.v / 4) * 160 + r.h / 4;
            SCENE_LOSE:  e.exp_addr = 43776 + (r.v / 8) * 80 + r.h / 8;
            SCENE_WIN:   e.exp_addr = 48576 + (r.v / 8) * 80 + r.h / 8;
            SCENE_PLAY: begin
                if (tile_shown(t, r.gate, r.spike)) begin
                    e.exp_addr = tile_rom_base(t) + (r.v % 32) * 32 + r.h % 32;
                end else if (h0) begin
                    e.exp_addr = sprite_addr(0, r);
                end else if (h1) begin
                    e.exp_addr = sprite_addr(1, r);
                end else begin
                    e.exp_addr = 0;
                end
            end
            default: e.exp_addr = 0;
        endcase
        e.exp_addr = e.exp_addr % (1 << 17);
        return e;
    endfunction

    // state seen by the DUT once a row has been held
    task automatic model_update(input row_t r);
        int px[2];
        int py[2];
        int cx;
        int k;
        px[0] = r.p0x;
        py[0] = r.p0y;
        px[1] = r.p1x;
        py[1] = r.p1y;
        if (r.fs) begin
            lat_x = px;
            lat_y = py;
        end
        if (r.scene == SCENE_START) begin
            ref_map = MAP_INIT;
        end else if (r.scene == SCENE_PLAY) begin
            for (k = 0; k < 2; k++) begin
                cx = px[k] + 16;
                if (cx < 640 && py[k] < 480 && ref_map[py[k] / 32][cx / 32] == 4'd11) begin
                    ref_map[py[k] / 32][cx / 32] = 4'd10;     // gold taken
                end
            end
        end
    endtask

    task automatic drive_row(input row_t r);
        scene        <= r.scene;
        h_cnt        <= coord_t'(r.h);
        v_cnt        <= coord_t'(r.v);
        p0_x         <= coord_t'(r.p0x);
        p0_y         <= coord_t'(r.p0y);
        p1_x         <= coord_t'(r.p1x);
        p1_y         <= coord_t'(r.p1y);
        p0_frame     <= frame_t'(r.f0);
        p1_frame     <= frame_t'(r.f1);
        p0_moving    <= r.mv0;
        p1_moving    <= r.mv1;
        p0_face_left <= r.fl0;
        p1_face_left <= r.fl1;
        gate_open    <= r.gate;
        spike_on     <= r.spike;
        frame_start  <= r.fs;
    endtask

    task automatic value_error(input string name, input int n, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("error: %s is 0x%0h, expected 0x%0h at step %0d", name, got, exp, n);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input row_t e, input int n);
        assert (pixel_addr === rom_addr_t'(e.exp_addr))
            else value_error("pixel_addr", n, pixel_addr, e.exp_addr);
    endtask

    task automatic check_flags(input row_t e, input int n);
        assert (show_pixel === e.exp_show)
            else value_error("show_pixel", n, show_pixel, e.exp_show);
        assert (tile_id === tile_t'(e.exp_tile))
            else value_error("tile_id", n, tile_id, e.exp_tile);
        assert (char0_on === e.exp_c0)
            else value_error("char0_on", n, char0_on, e.exp_c0);
        assert (char1_on === e.exp_c1)
            else value_error("char1_on", n, char1_on, e.exp_c1);
    endtask

    // watchdog allows six cycles per table row plus the stream
    initial begin
        wait (tbl_ready);
        #((tbl.size() * 6 + STREAM_N + 40) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        row_t r;
        row_t stream[STREAM_N];
        int   k;
        rst       = 1'b1;
        tbl_ready = 1'b0;
        rng       = 32'h68bf_e493;
        cur       = '{scene: SCENE_PLAY, gate: 3'b000, default: 0};
        drive_row(cur);
        lat_x     = '{32, 32};
        lat_y     = '{320, 416};
        ref_map   = MAP_INIT;
        build_table();
        tbl_ready = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        r = cur;
        r.exp_addr = 0;
        r.exp_show = 1'b0;
        r.exp_tile = 0;
        r.exp_c0   = 1'b0;
        r.exp_c1   = 1'b0;
        check_addr(r, -1);      // outputs cleared by reset
        check_flags(r, -1);
        @(posedge clk);
        rst <= 1'b0;

        foreach (tbl[i]) begin
            r = tbl[i];
            @(posedge clk);
            drive_row(r);
            @(posedge clk);
            frame_start <= 1'b0;
            repeat (3) @(posedge clk);
            @(negedge clk);
            model_update(r);
            if (!r.fixed) begin
                r = model_expect(r);
            end
            check_addr(r, i);
            check_flags(r, i);
        end

        // new scan position every cycle
        r       = tbl[tbl.size() - 1];
        r.scene = SCENE_PLAY;
        r.fs    = 1'b0;
        for (int i = 0; i < STREAM_N + 3; i++) begin
            @(posedge clk);
            if (i < STREAM_N) begin
                rng = lcg_next(rng);
                k   = int'(rng[30]);
                if (rng[31]) begin  // aim near a character window
                    r.h = lat_x[k] - 4 + int'(rng[21:16]) % 40;
                    r.v = lat_y[k] - 4 + int'(rng[13:8]) % 40;
                end else begin
                    r.h = int'(rng[25:16]) % 800;
                    r.v = int'(rng[9:0]) % 525;
                end
                stream[i] = model_expect(r);
                drive_row(r);
            end
            @(negedge clk);
            if (i >= 1 && i <= STREAM_N) begin
                check_addr(stream[i - 1], 1000 + i - 1);
            end
            if (i >= 3) begin
                check_flags(stream[i - 3], 1000 + i - 3);
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/scene_pkg.sv
verilog/tile_map_store.sv
verilog/player_window.sv
verilog/tile_decode.sv
verilog/pixel_addr_unit.sv
verilog/scene_addr_gen.sv
test/tb_scene_addr_gen.sv

// ==== Bender.yml ====
package:
  name: scene_addr_gen

sources:
  - verilog/scene_pkg.sv
  - verilog/tile_map_store.sv
  - verilog/player_window.sv
  - verilog/tile_decode.sv
  - verilog/pixel_addr_unit.sv
  - verilog/scene_addr_gen.sv
  - target: test
    files:
      - test/tb_scene_addr_gen.sv
